//--- src/cpu_defs.svh
// widths, memory depths and host address map for the cpu; included by the package and the RTL
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_DATA_W     16       // data and instruction word width
`define CPU_NUM_REGS   16       // register file entries

`define IMEM_DEPTH     256      // instruction memory words
`define DMEM_DEPTH     256      // data memory words

`define HOST_ADDR_W    12       // host byte address width

// host map, memory regions are 1 KB each and word index is addr[9:2]
`define HOST_IMEM_BASE 12'h000
`define HOST_DMEM_BASE 12'h400
`define HOST_CTRL_ADDR 12'h800  // bit 0 start or running, bit 1 halted

`endif

//--- src/cpu_pkg.sv
// shared types for the cpu datapath, controller and host bus; imported by RTL and testbench
package cpu_pkg;

  `include "cpu_defs.svh"

  typedef logic [`CPU_DATA_W-1:0]           word_t;
  typedef logic [`CPU_DATA_W-1:0]           instr_t;
  typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_addr_t;
  typedef logic [$clog2(`DMEM_DEPTH)-1:0]   mem_addr_t;
  typedef logic [`HOST_ADDR_W-1:0]          host_addr_t;
  typedef logic [31:0]                      axil_data_t;  // 32-bit bus, word uses low half

  typedef enum logic [3:0] {
    OP_NOOP  = 4'b0000,
    OP_LOAD  = 4'b0001,
    OP_STORE = 4'b0010,
    OP_ADD   = 4'b0011,
    OP_SUB   = 4'b0100,
    OP_HALT  = 4'b0101,
    OP_AND   = 4'b0110,
    OP_OR    = 4'b0111,
    OP_XOR   = 4'b1000
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  typedef enum logic [2:0] {
    IDLE,
    INIT,
    FETCH,
    DECODE,
    EXEC,
    HALT
  } ctrl_state_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    logic      src_mem;  // 1 writes the memory word, 0 the alu result
  } rf_ctrl_t;

  typedef struct packed {
    logic      en;
    logic      we;
    mem_addr_t addr;
    word_t     wdata;
  } dmem_req_t;

  typedef struct packed {
    logic pc_clr;
    logic pc_inc;
    logic ir_ld;
  } fetch_ctrl_t;

  typedef struct packed {
    logic       awvalid;
    host_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic [3:0] wstrb;  // full words only
    logic       bready;
  } axil_wr_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_e bresp;
  } axil_wr_rsp_t;

  typedef struct packed {
    logic       arvalid;
    host_addr_t araddr;
    logic       rready;
  } axil_rd_req_t;

  typedef struct packed {
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_e rresp;
  } axil_rd_rsp_t;

endpackage

//--- src/controller.sv
// run/halt FSM that decodes the instruction register and steers fetch, register file, alu and memory
`timescale 1ns/1ps

module controller
  import cpu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  instr_t      instr,
  output fetch_ctrl_t fetch_ctrl,
  output rf_ctrl_t    rf_ctrl,
  output alu_op_e     alu_op,
  output dmem_req_t   dmem_req,
  output logic        running,
  output logic        halted
);

  ctrl_state_e state;
  ctrl_state_e next_state;

  opcode_e   op;
  reg_addr_t rd;
  reg_addr_t ra;
  reg_addr_t rb;
  mem_addr_t maddr;

  // instruction fields
  assign op    = opcode_e'(instr[15:12]);
  assign rd    = instr[3:0];
  assign ra    = instr[11:8];
  assign rb    = instr[7:4];
  assign maddr = instr[11:4];

  assign running = (state == INIT) || (state == FETCH) || (state == DECODE) || (state == EXEC);
  assign halted  = (state == HALT);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= next_state;
    end
  end

  always_comb
  begin
    next_state = state;
    fetch_ctrl = '0;
    rf_ctrl    = '0;
    alu_op     = ALU_ADD;
    dmem_req   = '0;

    case (state)
      IDLE:
      begin
        if (start)
        begin
          next_state = INIT;
        end
      end

      INIT:
      begin
        fetch_ctrl.pc_clr = 1'b1;
        next_state        = FETCH;
      end

      FETCH:
      begin
        fetch_ctrl.ir_ld  = 1'b1;
        fetch_ctrl.pc_inc = 1'b1;
        next_state        = DECODE;
      end

      DECODE:
      begin
        if (op == OP_HALT)
        begin
          next_state = HALT;
        end
        else
        begin
          next_state = EXEC;
        end
        if (op == OP_LOAD)
        begin
          dmem_req.en   = 1'b1;   // word is ready in EXEC
          dmem_req.addr = maddr;
        end
      end

      EXEC:
      begin
        next_state = FETCH;
        case (op)
          OP_LOAD:
          begin
            rf_ctrl.we      = 1'b1;
            rf_ctrl.waddr   = rd;
            rf_ctrl.src_mem = 1'b1;
          end
          OP_STORE:
          begin
            rf_ctrl.raddr_a = rd;   // store data comes from port a
            dmem_req.en     = 1'b1;
            dmem_req.we     = 1'b1;
            dmem_req.addr   = maddr;
          end
          OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
          begin
            rf_ctrl.we      = 1'b1;
            rf_ctrl.waddr   = rd;
            rf_ctrl.raddr_a = ra;
            rf_ctrl.raddr_b = rb;
            case (op)
              OP_SUB:  alu_op = ALU_SUB;
              OP_AND:  alu_op = ALU_AND;
              OP_OR:   alu_op = ALU_OR;
              OP_XOR:  alu_op = ALU_XOR;
              default: alu_op = ALU_ADD;
            endcase
          end
          default:
          begin
            // noop and undefined opcodes
          end
        endcase
      end

      HALT:
      begin
        if (start)
        begin
          next_state = INIT;   // rerun from pc 0
        end
      end

      default:
      begin
        next_state = IDLE;
      end
    endcase
  end

  // an instruction writes either a register or memory
  assert property (@(posedge clk) disable iff (reset) !(rf_ctrl.we && dmem_req.we));

  assert property (@(posedge clk) disable iff (reset) !(running && halted));

endmodule

//--- src/instr_fetch.sv
// instruction memory loaded by the host, with the program counter and instruction register
`timescale 1ns/1ps
`include "cpu_defs.svh"

module instr_fetch
  import cpu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  fetch_ctrl_t fetch_ctrl,
  input  logic        host_we,
  input  mem_addr_t   host_addr,
  input  instr_t      host_wdata,
  output instr_t      instr
);

  instr_t    imem [`IMEM_DEPTH];
  mem_addr_t pc;
  instr_t    ir;

  always_ff @(posedge clk)
  begin
    if (host_we)
    begin
      imem[host_addr] <= host_wdata;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc <= '0;
    end
    else if (fetch_ctrl.pc_clr)
    begin
      pc <= '0;
    end
    else if (fetch_ctrl.pc_inc)
    begin
      pc <= pc + 1'b1;   // wraps after the last word
    end
  end

  always_ff @(posedge clk)
  begin
    if (fetch_ctrl.ir_ld)
    begin
      ir <= imem[pc];   // word at the old pc
    end
  end

  assign instr = ir;

  // host loads only while the cpu is stopped
  assert property (@(posedge clk) disable iff (reset) !(host_we && fetch_ctrl.pc_inc));

endmodule

//--- src/register_file.sv
// 16-entry register file with two combinational reads and one synchronous write
`timescale 1ns/1ps
`include "cpu_defs.svh"

module register_file
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  rf_ctrl_t rf_ctrl,
  input  word_t    alu_result,
  input  word_t    mem_rdata,
  output word_t    rdata_a,
  output word_t    rdata_b
);

  word_t regs [`CPU_NUM_REGS];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `CPU_NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (rf_ctrl.we)
    begin
      regs[rf_ctrl.waddr] <= rf_ctrl.src_mem ? mem_rdata : alu_result;
    end
  end

  assign rdata_a = regs[rf_ctrl.raddr_a];
  assign rdata_b = regs[rf_ctrl.raddr_b];

endmodule

//--- src/alu.sv
// combinational alu for the five register-to-register operations
`timescale 1ns/1ps

module alu
  import cpu_pkg::*;
(
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  always_comb
  begin
    case (op)
      ALU_ADD: result = a + b;   // wraps, no carry out
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      default: result = '0;
    endcase
  end

endmodule

//--- src/data_memory.sv
// data memory with registered read data, shared by the cpu and the host port
`timescale 1ns/1ps
`include "cpu_defs.svh"

module data_memory
  import cpu_pkg::*;
(
  input  logic      clk,
  input  dmem_req_t cpu_req,
  input  dmem_req_t host_req,
  output word_t     cpu_rdata,
  output word_t     host_rdata
);

  word_t mem [`DMEM_DEPTH];

  always_ff @(posedge clk)
  begin
    if (cpu_req.en)
    begin
      if (cpu_req.we)
      begin
        mem[cpu_req.addr] <= cpu_req.wdata;
      end
      else
      begin
        cpu_rdata <= mem[cpu_req.addr];
      end
    end
    if (host_req.en)
    begin
      if (host_req.we)
      begin
        mem[host_req.addr] <= host_req.wdata;
      end
      else
      begin
        host_rdata <= mem[host_req.addr];   // held until the next host read
      end
    end
  end

  // host gets memory only while the cpu is stopped
  assert property (@(posedge clk) !(cpu_req.en && host_req.en));

endmodule

//--- src/host_axil_port.sv
// AXI4-Lite slave giving the host access to both memories and the run control register
`timescale 1ns/1ps
`include "cpu_defs.svh"

module host_axil_port
  import cpu_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  axil_wr_req_t wr_req,
  input  axil_rd_req_t rd_req,
  input  logic         running,
  input  logic         halted,
  input  word_t        dmem_rdata,
  output axil_wr_rsp_t wr_rsp,
  output axil_rd_rsp_t rd_rsp,
  output logic         start,
  output logic         imem_we,
  output mem_addr_t    imem_addr,
  output instr_t       imem_wdata,
  output dmem_req_t    dmem_req
);

  typedef enum logic {W_IDLE, W_RESP} wr_state_e;
  typedef enum logic [1:0] {R_IDLE, R_ISSUE, R_RESP} rd_state_e;

  wr_state_e  wr_state;
  rd_state_e  rd_state;
  axil_resp_e bresp_q;
  axil_resp_e rresp_q;
  axil_data_t rdata_q;
  host_addr_t raddr_q;
  logic       rd_from_mem;

  logic wr_accept;
  logic wr_imem;
  logic wr_dmem;
  logic wr_ctrl;
  logic wr_err;
  logic wr_dmem_go;
  logic rd_dmem;
  logic rd_ctrl;
  logic rd_issue;

  // write address decode
  assign wr_imem = {wr_req.awaddr[11:10], 10'b0} == `HOST_IMEM_BASE;
  assign wr_dmem = {wr_req.awaddr[11:10], 10'b0} == `HOST_DMEM_BASE;
  assign wr_ctrl = wr_req.awaddr == `HOST_CTRL_ADDR;
  assign wr_err  = ((wr_imem || wr_dmem) && running) || !(wr_imem || wr_dmem || wr_ctrl);

  // held off while a read owns the memory port
  assign wr_accept = (wr_state == W_IDLE) && wr_req.awvalid && wr_req.wvalid &&
                     (rd_state != R_ISSUE);

  assign imem_we    = wr_accept && wr_imem && !running;
  assign imem_addr  = wr_req.awaddr[9:2];
  assign imem_wdata = wr_req.wdata[`CPU_DATA_W-1:0];
  assign start      = wr_accept && wr_ctrl && wr_req.wdata[0] && !running;
  assign wr_dmem_go = wr_accept && wr_dmem && !running;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_state <= W_IDLE;
    end
    else if (wr_accept)
    begin
      wr_state <= W_RESP;
    end
    else if ((wr_state == W_RESP) && wr_req.bready)
    begin
      wr_state <= W_IDLE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_accept)
    begin
      bresp_q <= wr_err ? SLVERR : OKAY;
    end
  end

  assign wr_rsp.awready = wr_accept;
  assign wr_rsp.wready  = wr_accept;
  assign wr_rsp.bvalid  = (wr_state == W_RESP);
  assign wr_rsp.bresp   = bresp_q;

  // read decode uses the captured address, imem has no read path
  assign rd_dmem  = {raddr_q[11:10], 10'b0} == `HOST_DMEM_BASE;
  assign rd_ctrl  = raddr_q == `HOST_CTRL_ADDR;
  assign rd_issue = (rd_state == R_ISSUE) && rd_dmem && !running;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_state <= R_IDLE;
    end
    else
    begin
      case (rd_state)
        R_IDLE:  if (rd_req.arvalid) rd_state <= R_ISSUE;
        R_ISSUE: rd_state <= R_RESP;
        R_RESP:  if (rd_req.rready) rd_state <= R_IDLE;
        default: rd_state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((rd_state == R_IDLE) && rd_req.arvalid)
    begin
      raddr_q <= rd_req.araddr;
    end
    if (rd_state == R_ISSUE)
    begin
      rd_from_mem <= rd_issue;
      rresp_q     <= (rd_issue || rd_ctrl) ? OKAY : SLVERR;
      rdata_q     <= rd_ctrl ? {30'b0, halted, running} : '0;   // status snapshot
    end
  end

  assign rd_rsp.arready = (rd_state == R_IDLE);
  assign rd_rsp.rvalid  = (rd_state == R_RESP);
  assign rd_rsp.rdata   = rd_from_mem ? {16'b0, dmem_rdata} : rdata_q;
  assign rd_rsp.rresp   = rresp_q;

  // one host memory access per cycle
  assign dmem_req.en    = rd_issue || wr_dmem_go;
  assign dmem_req.we    = wr_dmem_go;
  assign dmem_req.addr  = wr_dmem_go ? wr_req.awaddr[9:2] : raddr_q[9:2];
  assign dmem_req.wdata = wr_req.wdata[`CPU_DATA_W-1:0];

  assert property (@(posedge clk) disable iff (reset)
    wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid && $stable(wr_rsp.bresp));

endmodule

//--- src/cpu_top.sv
// top level of the multi-cycle cpu with its AXI4-Lite host port
`timescale 1ns/1ps

module cpu_top
  import cpu_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  axil_wr_req_t wr_req,
  output axil_wr_rsp_t wr_rsp,
  input  axil_rd_req_t rd_req,
  output axil_rd_rsp_t rd_rsp
);

  fetch_ctrl_t fetch_ctrl;
  rf_ctrl_t    rf_ctrl;
  alu_op_e     alu_op;
  dmem_req_t   ctrl_dmem_req;
  dmem_req_t   cpu_dmem_req;
  dmem_req_t   host_dmem_req;
  instr_t      instr;
  word_t       rf_rdata_a;
  word_t       rf_rdata_b;
  word_t       alu_result;
  word_t       cpu_rdata;
  word_t       host_rdata;
  logic        start;
  logic        running;
  logic        halted;
  logic        imem_we;
  mem_addr_t   imem_addr;
  instr_t      imem_wdata;

  // store data is register port a
  always_comb
  begin
    cpu_dmem_req       = ctrl_dmem_req;
    cpu_dmem_req.wdata = rf_rdata_a;
  end

  host_axil_port host_axil_port_i (
    .clk        (clk),
    .reset      (reset),
    .wr_req     (wr_req),
    .rd_req     (rd_req),
    .running    (running),
    .halted     (halted),
    .dmem_rdata (host_rdata),
    .wr_rsp     (wr_rsp),
    .rd_rsp     (rd_rsp),
    .start      (start),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .dmem_req   (host_dmem_req)
  );

  controller controller_i (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .instr      (instr),
    .fetch_ctrl (fetch_ctrl),
    .rf_ctrl    (rf_ctrl),
    .alu_op     (alu_op),
    .dmem_req   (ctrl_dmem_req),
    .running    (running),
    .halted     (halted)
  );

  instr_fetch instr_fetch_i (
    .clk        (clk),
    .reset      (reset),
    .fetch_ctrl (fetch_ctrl),
    .host_we    (imem_we),
    .host_addr  (imem_addr),
    .host_wdata (imem_wdata),
    .instr      (instr)
  );

  register_file register_file_i (
    .clk        (clk),
    .reset      (reset),
    .rf_ctrl    (rf_ctrl),
    .alu_result (alu_result),
    .mem_rdata  (cpu_rdata),
    .rdata_a    (rf_rdata_a),
    .rdata_b    (rf_rdata_b)
  );

  alu alu_i (
    .op     (alu_op),
    .a      (rf_rdata_a),
    .b      (rf_rdata_b),
    .result (alu_result)
  );

  data_memory data_memory_i (
    .clk        (clk),
    .cpu_req    (cpu_dmem_req),
    .host_req   (host_dmem_req),
    .cpu_rdata  (cpu_rdata),
    .host_rdata (host_rdata)
  );

endmodule

//--- dv/cpu_tb.sv
// self-checking testbench that runs random programs on cpu_top through the AXI4-Lite host port
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb
  import cpu_pkg::*;
();

  localparam int RAND_INSTRS    = 40;
  localparam int PROG_LEN       = RAND_INSTRS + `CPU_NUM_REGS + 1;  // random part plus dump and halt
  localparam int IMEM_SEEDS     = 8;
  localparam int READBACKS      = 32;
  localparam int NUM_INSTR      = 2 * PROG_LEN;
  localparam int HOST_TXNS      = 1 + `DMEM_DEPTH + IMEM_SEEDS + READBACKS +
                                  2 * (PROG_LEN + 1 + `DMEM_DEPTH) + 6 + NUM_INSTR;  // polls
  localparam int TIMEOUT_CYCLES = 4 * (NUM_INSTR * 3 + HOST_TXNS * 8) + 1000;

  logic         clk;
  logic         reset;
  axil_wr_req_t wr_req;
  axil_wr_rsp_t wr_rsp;
  axil_rd_req_t rd_req;
  axil_rd_rsp_t rd_rsp;

  word_t  model_regs [`CPU_NUM_REGS];
  word_t  model_mem  [`DMEM_DEPTH];
  instr_t prog [$];
  int     value_errors     = 0;
  int     handshake_errors = 0;
  int     cycle_count      = 0;

  cpu_top cpu_top_i (
    .clk    (clk),
    .reset  (reset),
    .wr_req (wr_req),
    .wr_rsp (wr_rsp),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_word(input string test, input word_t expected, input word_t actual);
    if (actual !== expected)
    begin
      $display("ERROR %s: expected %h, actual %h", test, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_resp(input string test, input axil_resp_e expected,
                            input axil_resp_e actual);
    if (actual !== expected)
    begin
      $display("ERROR %s: expected %s, actual %s", test, expected.name(), actual.name());
      value_errors++;
    end
  endtask

  function automatic host_addr_t dmem_addr(input mem_addr_t a);
    return `HOST_DMEM_BASE + {2'b00, a, 2'b00};
  endfunction

  function automatic host_addr_t imem_addr(input mem_addr_t a);
    return `HOST_IMEM_BASE + {2'b00, a, 2'b00};
  endfunction

  task automatic check_write_held(input host_addr_t addr, input axil_resp_e resp);
    if (!wr_rsp.bvalid || wr_rsp.bresp !== resp)
    begin
      $display("write response for address %h dropped or changed before bready", addr);
      handshake_errors++;
    end
  endtask

  task automatic check_read_held(input host_addr_t addr, input axil_data_t data,
                                 input axil_resp_e resp);
    if (!rd_rsp.rvalid || rd_rsp.rdata !== data || rd_rsp.rresp !== resp)
    begin
      $display("read response for address %h dropped or changed before rready", addr);
      handshake_errors++;
    end
  endtask

  task automatic axil_write(input host_addr_t addr, input axil_data_t data,
                            output axil_resp_e resp);
    int stall;
    stall = $urandom_range(3);
    @(posedge clk);
    wr_req.awvalid <= 1'b1;
    wr_req.awaddr  <= addr;
    wr_req.wvalid  <= 1'b1;
    wr_req.wdata   <= data;
    wr_req.wstrb   <= 4'hf;
    @(negedge clk);
    while (!wr_rsp.awready)
    begin
      @(negedge clk);
    end
    if (wr_rsp.wready !== 1'b1)
    begin
      $display("wready not raised together with awready for address %h", addr);
      handshake_errors++;
    end
    @(posedge clk);   // address and data accepted here
    wr_req.awvalid <= 1'b0;
    wr_req.wvalid  <= 1'b0;
    @(negedge clk);
    while (!wr_rsp.bvalid)
    begin
      @(negedge clk);
    end
    resp = wr_rsp.bresp;
    repeat (stall)
    begin
      @(negedge clk);
      check_write_held(addr, resp);
    end
    @(posedge clk);
    wr_req.bready <= 1'b1;
    @(negedge clk);
    check_write_held(addr, resp);
    @(posedge clk);
    wr_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input host_addr_t addr, output axil_data_t data,
                           output axil_resp_e resp);
    int stall;
    stall = $urandom_range(3);
    @(posedge clk);
    rd_req.arvalid <= 1'b1;
    rd_req.araddr  <= addr;
    @(negedge clk);
    while (!rd_rsp.arready)
    begin
      @(negedge clk);
    end
    @(posedge clk);
    rd_req.arvalid <= 1'b0;
    @(negedge clk);
    while (!rd_rsp.rvalid)
    begin
      @(negedge clk);
    end
    data = rd_rsp.rdata;
    resp = rd_rsp.rresp;
    repeat (stall)
    begin
      @(negedge clk);
      check_read_held(addr, data, resp);
    end
    @(posedge clk);
    rd_req.rready <= 1'b1;
    @(negedge clk);
    check_read_held(addr, data, resp);
    @(posedge clk);
    rd_req.rready <= 1'b0;
  endtask

  // 40 random instructions followed by a dump of every register to 240..255 and a halt
  function automatic void build_program();
    logic [3:0] op;
    prog.delete();
    for (int i = 0; i < RAND_INSTRS; i++)
    begin
      op = 4'($urandom_range(14));
      if (op >= 4'h5)
      begin
        op = op + 4'h1;   // skip halt
      end
      prog.push_back({op, 12'($urandom)});
    end
    for (int r = 0; r < `CPU_NUM_REGS; r++)
    begin
      prog.push_back({4'h2, 8'(240 + r), 4'(r)});
    end
    prog.push_back(16'h5000);
  endfunction

  // instruction set reference model
  function automatic void run_model_program();
    instr_t    ins;
    reg_addr_t rd;
    reg_addr_t ra;
    reg_addr_t rb;
    mem_addr_t m;
    foreach (prog[pc])
    begin
      ins = prog[pc];
      rd  = ins[3:0];
      ra  = ins[11:8];
      rb  = ins[7:4];
      m   = ins[11:4];
      if (ins[15:12] == 4'h5)
      begin
        break;
      end
      case (ins[15:12])
        4'h1:    model_regs[rd] = model_mem[m];
        4'h2:    model_mem[m] = model_regs[rd];
        4'h3:    model_regs[rd] = model_regs[ra] + model_regs[rb];
        4'h4:    model_regs[rd] = model_regs[ra] - model_regs[rb];
        4'h6:    model_regs[rd] = model_regs[ra] & model_regs[rb];
        4'h7:    model_regs[rd] = model_regs[ra] | model_regs[rb];
        4'h8:    model_regs[rd] = model_regs[ra] ^ model_regs[rb];
        default: ;   // noop
      endcase
    end
  endfunction

  task automatic load_and_start();
    axil_resp_e resp;
    foreach (prog[i])
    begin
      axil_write(imem_addr(mem_addr_t'(i)), {16'b0, prog[i]}, resp);
      check_resp("program load", OKAY, resp);
    end
    axil_write(`HOST_CTRL_ADDR, 32'h1, resp);
    check_resp("start", OKAY, resp);
  endtask

  task automatic wait_for_halt();
    axil_data_t status;
    axil_resp_e resp;
    status = '0;
    while (!status[1])
    begin
      axil_read(`HOST_CTRL_ADDR, status, resp);
      check_resp("status poll", OKAY, resp);
    end
    check_word("halt status", 16'h0002, status[15:0]);
  endtask

  task automatic compare_dmem(input string tag);
    axil_data_t rdata;
    axil_resp_e resp;
    for (int i = 0; i < `DMEM_DEPTH; i++)
    begin
      axil_read(dmem_addr(mem_addr_t'(i)), rdata, resp);
      check_resp($sformatf("%s dmem[%0d]", tag, i), OKAY, resp);
      check_word($sformatf("%s dmem[%0d]", tag, i), model_mem[i], rdata[15:0]);
    end
  endtask

  initial
  begin
    axil_data_t rdata;
    axil_resp_e resp;
    mem_addr_t  a;

    void'($urandom(2595));
    clk    = 1'b0;
    reset  = 1'b1;
    wr_req = '0;
    rd_req = '0;
    foreach (model_regs[i])
    begin
      model_regs[i] = '0;
    end
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    axil_read(`HOST_CTRL_ADDR, rdata, resp);
    check_resp("reset status", OKAY, resp);
    check_word("reset status", 16'h0000, rdata[15:0]);

    // idle host access to both memories
    for (int i = 0; i < `DMEM_DEPTH; i++)
    begin
      model_mem[i] = word_t'($urandom);
      axil_write(dmem_addr(mem_addr_t'(i)), {16'b0, model_mem[i]}, resp);
      check_resp("idle dmem write", OKAY, resp);
    end
    repeat (IMEM_SEEDS)
    begin
      axil_write(imem_addr(mem_addr_t'($urandom)), $urandom, resp);
      check_resp("idle imem write", OKAY, resp);
    end
    repeat (READBACKS)
    begin
      a = mem_addr_t'($urandom);
      axil_read(dmem_addr(a), rdata, resp);
      check_resp("idle dmem read", OKAY, resp);
      check_word("idle dmem read", model_mem[a], rdata[15:0]);
    end

    // first run with memory accesses while the cpu is busy
    build_program();
    load_and_start();
    a = mem_addr_t'($urandom);
    axil_write(dmem_addr(a), $urandom, resp);
    check_resp("busy dmem write", SLVERR, resp);
    axil_write(imem_addr(mem_addr_t'($urandom_range(PROG_LEN - 1))), $urandom, resp);
    check_resp("busy imem write", SLVERR, resp);
    axil_read(dmem_addr(a), rdata, resp);
    check_resp("busy dmem read", SLVERR, resp);
    check_word("busy dmem read", 16'h0000, rdata[15:0]);
    wait_for_halt();
    run_model_program();
    compare_dmem("run 1");

    // unmapped addresses
    axil_read(12'hc00 + {8'($urandom_range(255)), 2'b00}, rdata, resp);
    check_resp("unmapped read", SLVERR, resp);
    check_word("unmapped read", 16'h0000, rdata[15:0]);
    axil_read(12'h804, rdata, resp);
    check_resp("unmapped ctrl read", SLVERR, resp);
    check_word("unmapped ctrl read", 16'h0000, rdata[15:0]);
    axil_write(12'hffc, $urandom, resp);
    check_resp("unmapped write", SLVERR, resp);

    // second run keeps the registers of the first
    build_program();
    load_and_start();
    wait_for_halt();
    run_model_program();
    compare_dmem("run 2");

    $display("checks done: %0d value errors, %0d handshake errors",
             value_errors, handshake_errors);
    if (value_errors + handshake_errors == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+src
src/cpu_pkg.sv
src/controller.sv
src/instr_fetch.sv
src/register_file.sv
src/alu.sv
src/data_memory.sv
src/host_axil_port.sv
src/cpu_top.sv
dv/cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the cpu testbench with Verilator, runs it into sim.log and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module cpu_tb -f tb.f -o cpu_sim > sim.log 2>&1 &&
  ./obj_dir/cpu_sim >> sim.log 2>&1 ||
  { echo "build or simulation error, see sim.log"; exit 1; }

grep -q "TB FAILED" sim.log &&
  { echo "simulation failed, see sim.log"; exit 1; } ||
  { echo "simulation passed"; exit 0; }
